// File: design/mem_config.svh
`ifndef MEM_CONFIG_SVH
`define MEM_CONFIG_SVH

// data path and register width
`define MEM_DATA_W 32

// word address is byte address bits 31:2
`define MEM_WORD_ADDR_W 30

// log2 of implemented words, 256 words
`define MEM_DEPTH_W 8

// destination register index, 32 registers
`define MEM_REG_IDX_W 5

`endif

// File: design/mem_pkg.sv
package mem_pkg;

    // memory operation from the decoder
    typedef enum logic [2:0] {
        MEM_OP_NOP = 3'd0, // no memory access
        MEM_OP_LW  = 3'd1, // load word
        MEM_OP_LH  = 3'd2, // load half, sign extended
        MEM_OP_LHU = 3'd3, // load half, zero extended
        MEM_OP_LB  = 3'd4, // load byte, sign extended
        MEM_OP_LBU = 3'd5, // load byte, zero extended
        MEM_OP_SW  = 3'd6  // store word
    } mem_op_e;

    // direction on the memory port
    typedef enum logic {
        MEM_READ  = 1'b0,
        MEM_WRITE = 1'b1
    } mem_rw_e;

endpackage

// File: design/mem_bus_if.sv
`timescale 1ns/10ps
`include "mem_config.svh"

interface mem_bus_if;

    logic                        as_n;    // access strobe, active low
    mem_pkg::mem_rw_e            rw;
    logic [`MEM_WORD_ADDR_W-1:0] addr;    // word address
    logic [`MEM_DATA_W-1:0]      wr_data;
    logic [`MEM_DATA_W-1:0]      rd_data; // follows addr while as_n low

    modport ctrl (
        output as_n,
        output rw,
        output addr,
        output wr_data,
        input  rd_data
    );

    modport mem (
        input  as_n,
        input  rw,
        input  addr,
        input  wr_data,
        output rd_data
    );

endinterface

// File: design/mem_ctrl.sv
`timescale 1ns/10ps
`include "mem_config.svh"

module mem_ctrl (
    input  mem_pkg::mem_op_e       mem_op,    // from decode via execute
    input  logic [`MEM_DATA_W-1:0] alu_out,   // byte address or alu result
    input  logic [`MEM_DATA_W-1:0] gpr_data,  // store data
    mem_bus_if.ctrl                bus,
    output logic [`MEM_DATA_W-1:0] load_data, // extended load or alu result
    output logic                   is_load,   // aligned load
    output logic                   miss_align
);

    localparam int HALF_W = `MEM_DATA_W / 2;
    localparam int BYTE_W = `MEM_DATA_W / 4;
    localparam int OFFS_W = `MEM_DATA_W - `MEM_WORD_ADDR_W;

    logic [OFFS_W-1:0]      offset;
    logic                   aligned;
    logic                   ld_op;   // any load opcode
    logic                   st_op;   // store opcode
    logic [`MEM_DATA_W-1:0] rd_word;

    assign bus.addr    = alu_out[`MEM_DATA_W-1:OFFS_W];
    assign offset      = alu_out[OFFS_W-1:0];
    assign bus.wr_data = gpr_data; // full word always
    assign rd_word     = bus.rd_data;

    assign aligned = (offset == '0);

    // opcode class
    always_comb begin
        ld_op = 1'b0;
        st_op = 1'b0;
        case (mem_op)
            mem_pkg::MEM_OP_LW,
            mem_pkg::MEM_OP_LH,
            mem_pkg::MEM_OP_LHU,
            mem_pkg::MEM_OP_LB,
            mem_pkg::MEM_OP_LBU: begin
                ld_op = 1'b1;
            end
            mem_pkg::MEM_OP_SW: begin
                st_op = 1'b1;
            end
            default: begin
                ld_op = 1'b0; // nop and unused codes
                st_op = 1'b0;
            end
        endcase
    end

    // misaligned access never reaches memory
    always_comb begin
        bus.as_n   = 1'b1;
        bus.rw     = mem_pkg::MEM_READ;
        miss_align = 1'b0;
        if (ld_op || st_op) begin
            if (aligned) begin
                bus.as_n = 1'b0;
            end else begin
                miss_align = 1'b1;
            end
        end
        if (st_op) begin
            bus.rw = mem_pkg::MEM_WRITE;
        end
    end

    assign is_load = ld_op && aligned;

    // load extension, low lanes only
    always_comb begin
        load_data = alu_out; // pass alu result when not loading
        if (is_load) begin
            case (mem_op)
                mem_pkg::MEM_OP_LW: begin
                    load_data = rd_word;
                end
                mem_pkg::MEM_OP_LH: begin
                    load_data = {{(`MEM_DATA_W-HALF_W){rd_word[HALF_W-1]}},
                                 rd_word[HALF_W-1:0]};
                end
                mem_pkg::MEM_OP_LHU: begin
                    load_data = {{(`MEM_DATA_W-HALF_W){1'b0}}, rd_word[HALF_W-1:0]};
                end
                mem_pkg::MEM_OP_LB: begin
                    load_data = {{(`MEM_DATA_W-BYTE_W){rd_word[BYTE_W-1]}},
                                 rd_word[BYTE_W-1:0]};
                end
                mem_pkg::MEM_OP_LBU: begin
                    load_data = {{(`MEM_DATA_W-BYTE_W){1'b0}}, rd_word[BYTE_W-1:0]};
                end
                default: begin
                    load_data = alu_out;
                end
            endcase
        end
    end

endmodule

// File: design/data_mem.sv
`timescale 1ns/10ps
`include "mem_config.svh"

module data_mem #(
    parameter int DEPTH_W = `MEM_DEPTH_W
) (
    input logic   clk,
    mem_bus_if.mem bus
);

    localparam int WORDS = 2 ** DEPTH_W;

    logic [`MEM_DATA_W-1:0] mem [WORDS]; // contents not reset
    logic [DEPTH_W-1:0]     idx;
    logic                   wr_en;

    // upper word address bits are not decoded
    assign idx = bus.addr[DEPTH_W-1:0];

    assign wr_en = !bus.as_n && (bus.rw == mem_pkg::MEM_WRITE);

    // combinational read
    assign bus.rd_data = mem[idx];

    always_ff @(posedge clk) begin
        if (wr_en) begin
            mem[idx] <= bus.wr_data; // full word store
        end
    end

endmodule

// File: design/mem_wb_reg.sv
`timescale 1ns/10ps
`include "mem_config.svh"

module mem_wb_reg (
    input  logic                     clk,
    input  logic                     rst,
    input  logic [`MEM_DATA_W-1:0]   load_data,  // extended load or alu result
    input  logic                     is_load,
    input  logic                     miss_align,
    input  logic [`MEM_REG_IDX_W-1:0] dst_idx,
    input  logic                     dst_we,
    output logic [`MEM_DATA_W-1:0]   wb_data,
    output logic [`MEM_REG_IDX_W-1:0] wb_idx,
    output logic                     wb_we,
    output logic                     exc_miss_align
);

    always_ff @(posedge clk) begin
        if (rst) begin
            wb_data        <= '0;
            wb_idx         <= '0;
            wb_we          <= 1'b0;
            exc_miss_align <= 1'b0;
        end else begin
            wb_data        <= load_data; // load or alu result, chosen upstream
            wb_idx         <= dst_idx;
            wb_we          <= dst_we && !miss_align; // no write-back on exception
            exc_miss_align <= miss_align;
        end
    end

endmodule

// File: design/mem_stage_top.sv
`timescale 1ns/10ps
`include "mem_config.svh"

module mem_stage_top (
    input  logic                      clk,
    input  logic                      rst,
    input  logic [2:0]                mem_op,
    input  logic [`MEM_DATA_W-1:0]    alu_out,
    input  logic [`MEM_DATA_W-1:0]    gpr_data,
    input  logic [`MEM_REG_IDX_W-1:0] dst_idx,
    input  logic                      dst_we,
    output logic [`MEM_DATA_W-1:0]    wb_data,
    output logic [`MEM_REG_IDX_W-1:0] wb_idx,
    output logic                      wb_we,
    output logic                      exc_miss_align
);

    mem_pkg::mem_op_e       op;
    logic [`MEM_DATA_W-1:0] load_data;
    logic                   is_load;
    logic                   miss_align;

    assign op = mem_pkg::mem_op_e'(mem_op); // raw code to enum

    mem_bus_if bus ();

    mem_ctrl u_mem_ctrl (
        .mem_op     (op),
        .alu_out    (alu_out),
        .gpr_data   (gpr_data),
        .bus        (bus.ctrl),
        .load_data  (load_data),
        .is_load    (is_load),
        .miss_align (miss_align)
    );

    data_mem #(
        .DEPTH_W (`MEM_DEPTH_W)
    ) u_data_mem (
        .clk (clk),
        .bus (bus.mem)
    );

    // one cycle to write-back
    mem_wb_reg u_mem_wb_reg (
        .clk            (clk),
        .rst            (rst),
        .load_data      (load_data),
        .is_load        (is_load),
        .miss_align     (miss_align),
        .dst_idx        (dst_idx),
        .dst_we         (dst_we),
        .wb_data        (wb_data),
        .wb_idx         (wb_idx),
        .wb_we          (wb_we),
        .exc_miss_align (exc_miss_align)
    );

endmodule

// File: verif/tb_clock_gen.sv
`timescale 1ns/10ps

module tb_clock_gen #(
    parameter int PERIOD_NS = 8
) (
    output logic clk
);

    initial begin
        clk = 1'b0;
    end

    always begin
        #(PERIOD_NS / 2);
        clk = ~clk; // free running
    end

endmodule

// File: verif/mem_stage_assert.sv
`timescale 1ns/10ps
`include "mem_config.svh"

module mem_stage_assert (
    input logic                      clk,
    input logic                      rst,
    input logic [2:0]                mem_op,
    input logic [`MEM_DATA_W-1:0]    alu_out,
    input logic [`MEM_DATA_W-1:0]    gpr_data,
    input logic [`MEM_REG_IDX_W-1:0] dst_idx,
    input logic                      dst_we,
    input logic [`MEM_DATA_W-1:0]    wb_data,
    input logic [`MEM_REG_IDX_W-1:0] wb_idx,
    input logic                      wb_we,
    input logic                      exc_miss_align
);

    localparam int WORDS = 2 ** `MEM_DEPTH_W;

    int fail_cnt = 0; // read by the testbench

    logic [`MEM_DATA_W-1:0]    shadow [WORDS];
    bit   [WORDS-1:0]          written;  // shadow word holds a known value
    logic [`MEM_DEPTH_W-1:0]   widx;
    logic                      off_ok;
    logic                      is_ld;
    logic                      is_st;
    logic                      mis;
    logic [`MEM_DATA_W-1:0]    word;
    logic [`MEM_DATA_W-1:0]    exp_ld;
    logic [`MEM_DATA_W-1:0]    p_data;   // predictions for the next edge
    logic                      p_chk;
    logic                      p_we;
    logic                      p_exc;
    logic [`MEM_REG_IDX_W-1:0] p_idx;

    assign widx   = alu_out[`MEM_DEPTH_W+1:2];
    assign off_ok = (alu_out[1:0] == 2'b00);
    assign is_st  = (mem_op == mem_pkg::MEM_OP_SW);
    assign is_ld  = mem_op inside {mem_pkg::MEM_OP_LW, mem_pkg::MEM_OP_LH, mem_pkg::MEM_OP_LHU,
                                   mem_pkg::MEM_OP_LB, mem_pkg::MEM_OP_LBU};
    assign mis    = (is_ld || is_st) && !off_ok;
    assign word   = shadow[widx];

    // expected load value from the low lanes
    always_comb begin
        case (mem_op)
            mem_pkg::MEM_OP_LH:  exp_ld = {{16{word[15]}}, word[15:0]};
            mem_pkg::MEM_OP_LHU: exp_ld = {16'h0000, word[15:0]};
            mem_pkg::MEM_OP_LB:  exp_ld = {{24{word[7]}}, word[7:0]};
            mem_pkg::MEM_OP_LBU: exp_ld = {24'h000000, word[7:0]};
            default:             exp_ld = word;
        endcase
    end

    always_ff @(posedge clk) begin
        if (is_st && off_ok) begin
            shadow[widx]  <= gpr_data;
            written[widx] <= 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            p_data <= '0;
            p_chk  <= 1'b0;
            p_we   <= 1'b0;
            p_exc  <= 1'b0;
            p_idx  <= '0;
        end else begin
            p_idx <= dst_idx;
            p_we  <= dst_we && !mis;
            p_exc <= mis;
            if (is_ld && off_ok) begin
                p_data <= exp_ld;
                p_chk  <= written[widx]; // unwritten words are unknown
            end else begin
                p_data <= alu_out; // alu result passes through
                p_chk  <= 1'b1;
            end
        end
    end

    a_reset_quiet: assert property (@(posedge clk)
        $fell(rst) |-> !wb_we && !exc_miss_align && wb_data == '0)
        else begin
            $error("** Error at %0t: after reset wb_we %b exc_miss_align %b wb_data %h, expected 0",
                   $time, $sampled(wb_we), $sampled(exc_miss_align), $sampled(wb_data));
            fail_cnt++;
        end

    a_wb_we: assert property (@(posedge clk) disable iff (rst) wb_we == p_we)
        else begin
            $error("** Error at %0t: wb_we expected %b actual %b",
                   $time, $sampled(p_we), $sampled(wb_we));
            fail_cnt++;
        end

    a_wb_idx: assert property (@(posedge clk) disable iff (rst) wb_idx == p_idx)
        else begin
            $error("** Error at %0t: wb_idx expected %0d actual %0d",
                   $time, $sampled(p_idx), $sampled(wb_idx));
            fail_cnt++;
        end

    a_exc: assert property (@(posedge clk) disable iff (rst) exc_miss_align == p_exc)
        else begin
            $error("** Error at %0t: exc_miss_align expected %b actual %b",
                   $time, $sampled(p_exc), $sampled(exc_miss_align));
            fail_cnt++;
        end

    a_exc_no_we: assert property (@(posedge clk) disable iff (rst) exc_miss_align |-> !wb_we)
        else begin
            $error("write-back enabled at %0t in the same cycle as a misalignment exception",
                   $time);
            fail_cnt++;
        end

    a_wb_data: assert property (@(posedge clk) disable iff (rst) p_chk |-> wb_data == p_data)
        else begin
            $error("** Error at %0t: wb_data expected %h actual %h",
                   $time, $sampled(p_data), $sampled(wb_data));
            fail_cnt++;
        end

endmodule

bind mem_stage_top mem_stage_assert u_assert (.*);

// File: verif/tb_mem_stage.sv
`timescale 1ns/10ps
`include "mem_config.svh"

module tb_mem_stage;

    localparam int        CLK_PERIOD = 8;
    localparam bit [31:0] SEED       = 32'h47d0_cf1d;
    localparam int        RESET_CYC  = 2;
    localparam int        IDLE_CYC   = 8;
    localparam int        PAIR_CNT   = 16;
    localparam int        EXT_WORDS  = 4;
    localparam int        MIX_CYC    = 200;
    localparam int        DRAIN_CYC  = 3;
    localparam int        TOTAL_CYC  = RESET_CYC + IDLE_CYC + 2 * PAIR_CNT + 5 * EXT_WORDS
                                       + 4 * 3 + MIX_CYC + 5 * (DRAIN_CYC + 1);
    localparam int        LIMIT_NS   = 2 * TOTAL_CYC * CLK_PERIOD + 100; // double plus margin

    logic                      clk;
    logic                      rst;
    logic [2:0]                mem_op;
    logic [`MEM_DATA_W-1:0]    alu_out;
    logic [`MEM_DATA_W-1:0]    gpr_data;
    logic [`MEM_REG_IDX_W-1:0] dst_idx;
    logic                      dst_we;
    logic [`MEM_DATA_W-1:0]    wb_data;
    logic [`MEM_REG_IDX_W-1:0] wb_idx;
    logic                      wb_we;
    logic                      exc_miss_align;

    int          errs_total   = 0;
    int          tests_failed = 0;
    logic [31:0] pool [$]; // addresses holding stored words

    tb_clock_gen #(.PERIOD_NS(CLK_PERIOD)) u_clk (.clk(clk));

    mem_stage_top dut (
        .clk            (clk),
        .rst            (rst),
        .mem_op         (mem_op),
        .alu_out        (alu_out),
        .gpr_data       (gpr_data),
        .dst_idx        (dst_idx),
        .dst_we         (dst_we),
        .wb_data        (wb_data),
        .wb_idx         (wb_idx),
        .wb_we          (wb_we),
        .exc_miss_align (exc_miss_align)
    );

    function automatic logic [31:0] rand_word_addr();
        return $urandom() & 32'hffff_fffc; // upper bits alias in memory
    endfunction

    function automatic logic [`MEM_REG_IDX_W-1:0] rand_idx();
        return `MEM_REG_IDX_W'($urandom());
    endfunction

    // one access per cycle, 1 ns after the edge
    task automatic apply(input mem_pkg::mem_op_e op, input logic [31:0] addr,
                         input logic [31:0] data, input logic [`MEM_REG_IDX_W-1:0] idx,
                         input logic we);
        @(posedge clk);
        #1;
        mem_op   = op;
        alu_out  = addr;
        gpr_data = data;
        dst_idx  = idx;
        dst_we   = we;
    endtask

    task automatic idle(input int n);
        repeat (n) apply(mem_pkg::MEM_OP_NOP, 32'h0, 32'h0, '0, 1'b0);
    endtask

    task automatic close_test(input string name, input int start);
        int errs;
        idle(DRAIN_CYC); // let the last result be checked
        errs = dut.u_assert.fail_cnt - start;
        errs_total += errs;
        if (errs != 0) tests_failed++;
        $display("%s errors %0d", name, errs);
    endtask

    initial begin
        #(LIMIT_NS);
        $display("watchdog expired after %0d ns with tests still running", LIMIT_NS);
        $display("Finished with errors");
        $finish;
    end

    initial begin
        int          start;
        logic [31:0] a;
        logic [31:0] pat [EXT_WORDS];
        mem_pkg::mem_op_e op;

        rst      = 1'b1;
        mem_op   = mem_pkg::MEM_OP_NOP;
        alu_out  = '0;
        gpr_data = '0;
        dst_idx  = '0;
        dst_we   = 1'b0;
        void'($urandom(SEED));
        pat = '{32'h1234_8081, 32'hfedc_0081, 32'h0f0f_807f, 32'hc3c3_7f7f}; // half/byte sign mix

        repeat (RESET_CYC) @(posedge clk);
        #1;
        rst = 1'b0;

        start = dut.u_assert.fail_cnt;
        idle(IDLE_CYC);
        close_test("reset_idle", start);

        start = dut.u_assert.fail_cnt;
        for (int i = 0; i < PAIR_CNT; i++) begin
            a = rand_word_addr();
            pool.push_back(a);
            apply(mem_pkg::MEM_OP_SW, a, $urandom(), rand_idx(), 1'($urandom()));
            apply(mem_pkg::MEM_OP_LW, a, $urandom(), rand_idx(), 1'b1);
        end
        close_test("store_load", start);

        start = dut.u_assert.fail_cnt;
        for (int i = 0; i < EXT_WORDS; i++) begin
            a = rand_word_addr();
            pool.push_back(a);
            apply(mem_pkg::MEM_OP_SW, a, pat[i], rand_idx(), 1'b0);
            apply(mem_pkg::MEM_OP_LH, a, 32'h0, rand_idx(), 1'b1);
            apply(mem_pkg::MEM_OP_LHU, a, 32'h0, rand_idx(), 1'b1);
            apply(mem_pkg::MEM_OP_LB, a, 32'h0, rand_idx(), 1'b1);
            apply(mem_pkg::MEM_OP_LBU, a, 32'h0, rand_idx(), 1'b1);
        end
        close_test("subword_ext", start);

        start = dut.u_assert.fail_cnt;
        for (int off = 1; off < 4; off++) begin
            a = pool[$urandom_range(pool.size() - 1, 0)];
            apply(mem_pkg::MEM_OP_SW, a | off, ~$urandom(), rand_idx(), 1'b1);
            apply(mem_pkg::MEM_OP_LW, a | off, 32'h0, rand_idx(), 1'b1);
            apply(mem_pkg::MEM_OP_LHU, a | off, 32'h0, rand_idx(), 1'b1);
            apply(mem_pkg::MEM_OP_LW, a, 32'h0, rand_idx(), 1'b1); // word must be unchanged
        end
        close_test("misaligned", start);

        start = dut.u_assert.fail_cnt;
        for (int i = 0; i < MIX_CYC; i++) begin
            op = mem_pkg::mem_op_e'($urandom_range(6, 0));
            if ($urandom_range(1, 0) == 0) begin
                a = pool[$urandom_range(pool.size() - 1, 0)];
            end else begin
                a = rand_word_addr();
            end
            if ($urandom_range(7, 0) == 0) begin
                a = a | $urandom_range(3, 1); // occasional misaligned access
            end else if (op == mem_pkg::MEM_OP_SW) begin
                pool.push_back(a);
            end
            apply(op, a, $urandom(), rand_idx(), 1'($urandom()));
        end
        close_test("back_to_back", start);

        $display("summary: 5 tests, %0d failed, %0d assertion errors", tests_failed, errs_total);
        if (errs_total == 0) begin
            $display("Finished with no errors");
        end else begin
            $display("Finished with errors");
        end
        $finish;
    end

endmodule

// File: compile.f
+incdir+design
design/mem_pkg.sv
design/mem_bus_if.sv
design/mem_ctrl.sv
design/data_mem.sv
design/mem_wb_reg.sv
design/mem_stage_top.sv
verif/tb_clock_gen.sv
verif/mem_stage_assert.sv
verif/tb_mem_stage.sv

// File: Bender.yml
package:
  name: mem_stage

export_include_dirs:
  - design

sources:
  - include_dirs:
      - design
    files:
      - design/mem_pkg.sv
      - design/mem_bus_if.sv
      - design/mem_ctrl.sv
      - design/data_mem.sv
      - design/mem_wb_reg.sv
      - design/mem_stage_top.sv

  - target: simulation
    include_dirs:
      - design
    files:
      - verif/tb_clock_gen.sv
      - verif/mem_stage_assert.sv
      - verif/tb_mem_stage.sv
